/* include/buffer_defines.svh */
// endpoint buffer geometry shared by the package, the byte store and the request decoder
`ifndef BUFFER_DEFINES_SVH
`define BUFFER_DEFINES_SVH

// *************************************************************************
// storage geometry
// *************************************************************************
// depth must be even but need not be a power of two
`define BUF_DEPTH 64    // number of byte slots
`define BUF_AW 6        // pointer width covering 0 to BUF_DEPTH-1
`define OCC_W 7         // occupancy width holding 0 to BUF_DEPTH

// *************************************************************************
// AHB side word
// *************************************************************************
`define WORD_BYTES 4    // bytes in one AHB data word

// byte lanes are always 8 bits wide

`endif

/* design/buffer_pkg.sv */
// endpoint buffer types for bytes, words, counts and the store command and view
`include "buffer_defines.svh"

package buffer_pkg;

  // *************************************************************************
  // plain vector types
  // *************************************************************************
  typedef logic [7:0] byte_t;                    // one data byte
  typedef logic [`WORD_BYTES*8-1:0] word_t;      // AHB word with byte 0 in the low bits
  typedef logic [`OCC_W-1:0] occ_t;              // bytes held in the buffer
  typedef logic [1:0] size_code_t;               // AHB size code meaning code+1 bytes
  typedef logic [2:0] bcount_t;                  // bytes moved in one cycle (0 to 4)

  // *************************************************************************
  // decoder to store
  // *************************************************************************
  typedef struct packed {
    bcount_t wr_count;    // bytes to append at the write pointer
    word_t   wr_word;     // write data with the first byte low
    bcount_t rd_count;    // bytes to drop at the read pointer
    logic    clr;         // empty the buffer
  } buf_cmd_t;

  // store back to decoder
  typedef struct packed {
    word_t head_word;     // four bytes from the read pointer with the oldest low
    occ_t  occupancy;     // registered byte count
  } buf_view_t;

endpackage

/* design/buffer_store.sv */
// circular byte store of the endpoint buffer with wrapping pointers and occupancy count
`include "buffer_defines.svh"

module buffer_store (
  input  logic                  tb_clk,
  input  logic                  arst_n,
  input  buffer_pkg::buf_cmd_t  cmd,     // counts already checked by the decoder
  output buffer_pkg::buf_view_t view     // head bytes and occupancy
);
  import buffer_pkg::*;

  // pointer into the byte array
  typedef logic [`BUF_AW-1:0] ptr_t;

  // depth one bit wider than a pointer for the wrap compare
  localparam logic [`BUF_AW:0] depth_ext = `BUF_DEPTH;

  // *************************************************************************
  // state
  // *************************************************************************
  byte_t mem [`BUF_DEPTH];   // payload bytes
  ptr_t  wr_ptr;             // next free slot
  ptr_t  rd_ptr;             // oldest held byte
  occ_t  occ_cnt;            // bytes held
  word_t head_word;          // bytes at rd_ptr

  // *************************************************************************
  // pointer arithmetic modulo the depth
  // *************************************************************************
  // works for any even depth since the step never exceeds one word
  function automatic ptr_t wrap_add(ptr_t base, bcount_t step);
    logic [`BUF_AW:0] sum;
    sum = {1'b0, base} + {{(`BUF_AW-2){1'b0}}, step};
    if (sum >= depth_ext) begin
      sum = sum - depth_ext;    // fold back past the last slot
    end
    return sum[`BUF_AW-1:0];
  endfunction

  // *************************************************************************
  // byte writes
  // *************************************************************************
  // up to one word per cycle and lane i lands at wr_ptr+i
  always_ff @(posedge tb_clk) begin
    if (!cmd.clr) begin                          // clear drops the write
      for (int i = 0; i < `WORD_BYTES; i++) begin
        if (bcount_t'(i) < cmd.wr_count) begin   // only the requested lanes
          mem[wrap_add(wr_ptr, bcount_t'(i))] <= cmd.wr_word[8*i +: 8];
        end
      end
    end
  end

  // *************************************************************************
  // pointers and occupancy
  // *************************************************************************
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      occ_cnt <= '0;
    end else if (cmd.clr) begin
      // empty buffer and both pointers home
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      occ_cnt <= '0;
    end else begin
      wr_ptr  <= wrap_add(wr_ptr, cmd.wr_count);    // zero count holds
      rd_ptr  <= wrap_add(rd_ptr, cmd.rd_count);
      // push and pop in one cycle net out here
      occ_cnt <= occ_cnt + occ_t'(cmd.wr_count) - occ_t'(cmd.rd_count);
    end
  end

  // *************************************************************************
  // head view
  // *************************************************************************
  // oldest byte in lane 0 and later bytes above it
  always_comb begin
    head_word = '0;
    for (int i = 0; i < `WORD_BYTES; i++) begin
      head_word[8*i +: 8] = mem[wrap_add(rd_ptr, bcount_t'(i))];
    end
  end

  // stale lanes beyond occupancy are masked by the consumer
  assign view = '{head_word: head_word, occupancy: occ_cnt};

endmodule

/* design/data_buffer.sv */
// endpoint buffer request decoder that gates, sizes and checks each strobe for the store
`include "buffer_defines.svh"

module data_buffer (
  input  logic                   clear,                 // empty the buffer
  input  logic                   store_rx_packet_data,  // usb rx byte strobe
  input  buffer_pkg::byte_t      rx_packet_data,
  input  logic                   get_rx_data,           // ahb read pop
  input  buffer_pkg::size_code_t data_size,             // ahb size for both directions
  input  buffer_pkg::word_t      tx_data,
  input  logic                   store_tx_data,         // ahb write strobe
  input  logic                   get_tx_packet_data,    // usb tx byte pop
  input  logic                   buffer_reserved,       // high while the ahb side owns writes
  input  buffer_pkg::buf_view_t  view,
  output buffer_pkg::buf_cmd_t   cmd,
  output buffer_pkg::occ_t       buffer_occupancy,
  output buffer_pkg::word_t      rx_data,
  output buffer_pkg::byte_t      tx_packet_data
);
  import buffer_pkg::*;

  // *************************************************************************
  // request decode
  // *************************************************************************
  bcount_t size_bytes;   // data_size+1
  bcount_t wr_want;      // bytes the accepted store would append
  word_t   wr_word;      // data for that store
  bcount_t rd_want;      // bytes the winning pop would drop
  occ_t    free_space;   // empty slots before the edge
  logic    wr_fits;
  logic    rd_fits;

  assign size_bytes = bcount_t'(data_size) + bcount_t'(1);

  // the two stores never pass together since ownership is one level
  always_comb begin
    wr_want = '0;
    wr_word = '0;
    if (store_rx_packet_data && !buffer_reserved) begin
      wr_want = bcount_t'(1);               // single usb byte
      wr_word = word_t'(rx_packet_data);
    end else if (store_tx_data && buffer_reserved) begin
      wr_want = size_bytes;                 // low bytes of the ahb word
      wr_word = tx_data;
    end
  end

  // get_rx_data wins over the usb pop
  always_comb begin
    rd_want = '0;
    if (get_rx_data) begin
      rd_want = size_bytes;
    end else if (get_tx_packet_data) begin
      rd_want = bcount_t'(1);
    end
  end

  // *************************************************************************
  // overflow and underflow rejection
  // *************************************************************************
  // both tests use the occupancy held before the edge
  assign free_space = occ_t'(`BUF_DEPTH) - view.occupancy;
  assign wr_fits    = occ_t'(wr_want) <= free_space;       // else drop the whole write
  assign rd_fits    = occ_t'(rd_want) <= view.occupancy;   // else ignore the whole pop

  always_comb begin
    cmd     = '0;
    cmd.clr = clear;              // clear overrides everything else
    if (!clear) begin
      if (wr_fits) begin
        cmd.wr_count = wr_want;
        cmd.wr_word  = wr_word;
      end
      if (rd_fits) begin
        cmd.rd_count = rd_want;
      end
    end
  end

  // *************************************************************************
  // read views
  // *************************************************************************
  // keep the oldest data_size+1 bytes and zero the rest
  always_comb begin
    rx_data = '0;
    for (int i = 0; i < `WORD_BYTES; i++) begin
      if (bcount_t'(i) < size_bytes) begin
        rx_data[8*i +: 8] = view.head_word[8*i +: 8];
      end
    end
  end

  assign tx_packet_data   = view.head_word[7:0];   // oldest byte
  assign buffer_occupancy = view.occupancy;

endmodule

/* design/endpoint_buffer_top.sv */
// usb endpoint data buffer top joining the request decoder to the circular byte store
module endpoint_buffer_top (
  input  logic                   tb_clk,
  input  logic                   arst_n,
  input  logic                   clear,
  input  logic                   store_rx_packet_data,
  input  buffer_pkg::byte_t      rx_packet_data,
  input  logic                   get_rx_data,
  input  buffer_pkg::size_code_t data_size,
  input  buffer_pkg::word_t      tx_data,
  input  logic                   store_tx_data,
  input  logic                   get_tx_packet_data,
  input  logic                   buffer_reserved,
  output buffer_pkg::occ_t       buffer_occupancy,
  output buffer_pkg::word_t      rx_data,
  output buffer_pkg::byte_t      tx_packet_data
);
  import buffer_pkg::*;

  // *************************************************************************
  // decoder to store link
  // *************************************************************************
  buf_cmd_t  cmd;    // combinational command for this edge
  buf_view_t view;   // registered occupancy and head bytes

  data_buffer u_data_buffer (
    .clear                (clear),
    .store_rx_packet_data (store_rx_packet_data),
    .rx_packet_data       (rx_packet_data),
    .get_rx_data          (get_rx_data),
    .data_size            (data_size),
    .tx_data              (tx_data),
    .store_tx_data        (store_tx_data),
    .get_tx_packet_data   (get_tx_packet_data),
    .buffer_reserved      (buffer_reserved),
    .view                 (view),
    .cmd                  (cmd),
    .buffer_occupancy     (buffer_occupancy),
    .rx_data              (rx_data),
    .tx_packet_data       (tx_packet_data)
  );

  // one cycle from command to pointer and count update
  buffer_store u_buffer_store (
    .tb_clk (tb_clk),
    .arst_n (arst_n),
    .cmd    (cmd),
    .view   (view)
  );

endmodule

/* bench/buffer_checker.sv */
// endpoint buffer scoreboard that mirrors the held bytes in a queue and compares every cycle
`include "buffer_defines.svh"

module buffer_checker (
  input  logic                   tb_clk,
  input  logic                   arst_n,
  input  logic                   clear,
  input  logic                   store_rx_packet_data,
  input  buffer_pkg::byte_t      rx_packet_data,
  input  logic                   get_rx_data,
  input  buffer_pkg::size_code_t data_size,
  input  buffer_pkg::word_t      tx_data,
  input  logic                   store_tx_data,
  input  logic                   get_tx_packet_data,
  input  logic                   buffer_reserved,
  input  buffer_pkg::occ_t       buffer_occupancy,
  input  buffer_pkg::word_t      rx_data,
  input  buffer_pkg::byte_t      tx_packet_data,
  output int                     occ_errors,    // occupancy mismatches
  output int                     data_errors,   // rx_data or tx_packet_data mismatches
  output int                     data_checks,   // pops whose data was compared
  output int                     wrap_reads     // compared pops that reached past the wrap
);
  import buffer_pkg::*;

  byte_t model_q[$];          // oldest byte at the front
  int    occ_errs    = 0;
  int    data_errs   = 0;
  int    checks_done = 0;
  int    seg_read    = 0;     // bytes popped since the last reset or clear
  int    wrap_cnt    = 0;

  assign occ_errors  = occ_errs;
  assign data_errors = data_errs;
  assign data_checks = checks_done;
  assign wrap_reads  = wrap_cnt;

  // *************************************************************************
  // one cycle of the model
  // *************************************************************************
  // inputs and outputs are both settled at the falling edge
  // the model then steps to what the next rising edge should leave behind
  task automatic check_cycle();
    int    n_size;
    int    wr_n;
    int    rd_n;
    int    held;
    word_t expect_word;
    word_t wr_bytes;
    if (!arst_n) begin
      model_q.delete();           // reset empties the store
      seg_read = 0;
      return;
    end
    held = model_q.size();
    if (buffer_occupancy !== occ_t'(held)) begin
      occ_errs++;
      $display("Error at %0t: buffer_occupancy is %0d, model holds %0d bytes",
               $time, buffer_occupancy, held);
    end
    if (clear) begin
      model_q.delete();           // clear beats every other request
      seg_read = 0;
      return;
    end
    n_size = int'(data_size) + 1;
    // store side, only the owner's strobe counts
    wr_n     = 0;
    wr_bytes = '0;
    if (store_rx_packet_data && !buffer_reserved) begin
      wr_n     = 1;
      wr_bytes = word_t'(rx_packet_data);
    end else if (store_tx_data && buffer_reserved) begin
      wr_n     = n_size;
      wr_bytes = tx_data;
    end
    // pop side where the ahb read wins
    rd_n = 0;
    if (get_rx_data) rd_n = n_size;
    else if (get_tx_packet_data) rd_n = 1;
    // an underflowing pop is ignored whole
    if (rd_n > 0 && rd_n <= held) begin
      checks_done++;
      if (get_rx_data) begin
        expect_word = '0;                                // zero above the requested bytes
        for (int i = 0; i < rd_n; i++) expect_word[8*i +: 8] = model_q[i];
        if (rx_data !== expect_word) begin
          data_errs++;
          $display("Error at %0t: rx_data is %h, expected %h for %0d bytes",
                   $time, rx_data, expect_word, rd_n);
        end
      end else if (tx_packet_data !== model_q[0]) begin
        data_errs++;
        $display("Error at %0t: tx_packet_data is %h, expected %h",
                 $time, tx_packet_data, model_q[0]);
      end
      repeat (rd_n) void'(model_q.pop_front());
      seg_read += rd_n;
      // more than a full depth read in one run of pops means the read pointer wrapped
      if (seg_read > `BUF_DEPTH) wrap_cnt++;
    end
    // free space judged on the count before the edge and overflow dropped whole
    if (wr_n > 0 && wr_n <= `BUF_DEPTH - held) begin
      for (int i = 0; i < wr_n; i++) model_q.push_back(wr_bytes[8*i +: 8]);   // byte 0 first
    end
  endtask

  always @(negedge tb_clk) begin
    check_cycle();
  end

endmodule

/* bench/tb_endpoint_buffer.sv */
// endpoint buffer testbench driving seeded random fill and drain traffic into dut0
`include "buffer_defines.svh"

module tb_endpoint_buffer;
  import buffer_pkg::*;

  // *************************************************************************
  // run length
  // *************************************************************************
  localparam int reset_cycles = 10;
  localparam int stim_cycles  = 2000;
  localparam int max_cycles   = reset_cycles + stim_cycles + 90;   // 2100 with drain room

  logic       tb_clk = 1'b0;
  logic       arst_n;
  logic       clear;
  logic       store_rx_packet_data;
  byte_t      rx_packet_data;
  logic       get_rx_data;
  size_code_t data_size;
  word_t      tx_data;
  logic       store_tx_data;
  logic       get_tx_packet_data;
  logic       buffer_reserved;
  occ_t       buffer_occupancy;
  word_t      rx_data;
  byte_t      tx_packet_data;
  int         occ_errors;
  int         data_errors;
  int         data_checks;
  int         wrap_reads;
  int         cycle_count = 0;
  integer     seed;
  logic       fill_phase;       // high while stores outweigh pops
  logic       passed;

  always #20 tb_clk = ~tb_clk;  // 40 unit period

  endpoint_buffer_top dut0 (.*);

  // watches the same ports as dut0
  buffer_checker chk0 (.*);

  // *************************************************************************
  // stimulus
  // *************************************************************************
  function automatic int pick(int range);
    return int'($unsigned($random(seed)) % range);
  endfunction

  task automatic idle_inputs();
    clear                <= 1'b0;
    store_rx_packet_data <= 1'b0;
    rx_packet_data       <= '0;
    get_rx_data          <= 1'b0;
    data_size            <= '0;
    tx_data              <= '0;
    store_tx_data        <= 1'b0;
    get_tx_packet_data   <= 1'b0;
  endtask

  // strobes are drawn independently so wrong-owner stores and double pops occur
  task automatic drive_random_cycle();
    if (pick(50) == 0) buffer_reserved <= !buffer_reserved;   // ownership swap
    if (pick(100) == 0) fill_phase = !fill_phase;
    clear                <= (pick(100) == 0);
    store_rx_packet_data <= (pick(100) < (fill_phase ? 75 : 20));
    store_tx_data        <= (pick(100) < (fill_phase ? 70 : 15));
    get_rx_data          <= (pick(100) < (fill_phase ? 10 : 45));
    get_tx_packet_data   <= (pick(100) < (fill_phase ? 15 : 50));
    data_size            <= size_code_t'(pick(4));
    rx_packet_data       <= byte_t'($random(seed));
    tx_data              <= word_t'($random(seed));
  endtask

  initial begin
    seed       = 32'h446a;
    fill_phase = 1'b1;
    arst_n          <= 1'b0;
    buffer_reserved <= 1'b0;
    idle_inputs();
    repeat (reset_cycles) @(posedge tb_clk);
    arst_n <= 1'b1;
    repeat (stim_cycles) begin
      @(posedge tb_clk);
      drive_random_cycle();
    end
    @(posedge tb_clk);
    idle_inputs();
    repeat (2) @(posedge tb_clk);
    // *************************************************************************
    // result
    // *************************************************************************
    $display("occupancy errors: %0d, data errors: %0d, data checks: %0d, wrap reads: %0d",
             occ_errors, data_errors, data_checks, wrap_reads);
    if (data_checks == 0) $display("no popped data was ever compared");
    if (wrap_reads == 0) $display("reads never passed the end of the store");
    passed = (occ_errors == 0) && (data_errors == 0) && (data_checks > 0) &&
             (wrap_reads > 0);
    if (passed) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // stops a run that overstays the stimulus length
  always @(posedge tb_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run still going after %0d cycles", max_cycles);
      $display("Errors found");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+include
design/buffer_pkg.sv
design/buffer_store.sv
design/data_buffer.sv
design/endpoint_buffer_top.sv
bench/buffer_checker.sv
bench/tb_endpoint_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the endpoint buffer testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f project.f --top-module tb_endpoint_buffer \
  -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$log_file"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
